//--- hw/ipod_pkg.sv
package ipod_pkg;

  // ========================================
  // Bus and data widths
  // ========================================
  localparam int ADDR_W   = 23;
  localparam int DATA_W   = 32;
  localparam int SAMPLE_W = 8;
  localparam int COUNT_W  = 16;

  // ========================================
  // Sample rate divider
  // ========================================
  // 50 MHz / (1136 + 1) is close to 44 kHz
  localparam logic [COUNT_W-1:0] COUNT_DEFAULT = 16'h0470;
  localparam logic [COUNT_W-1:0] COUNT_STEP    = 16'd32;
  localparam logic [COUNT_W-1:0] COUNT_MIN     = 16'd256;
  localparam logic [COUNT_W-1:0] COUNT_MAX     = 16'd4095;

  // Last word of the song in flash
  localparam logic [ADDR_W-1:0] FLASH_LAST_ADDR = 23'h7FFFF;

  // ========================================
  // ASCII command codes
  // ========================================
  localparam logic [SAMPLE_W-1:0] CMD_PLAY     = 8'h45;
  localparam logic [SAMPLE_W-1:0] CMD_STOP     = 8'h44;
  localparam logic [SAMPLE_W-1:0] CMD_FORWARD  = 8'h46;
  localparam logic [SAMPLE_W-1:0] CMD_BACKWARD = 8'h42;
  localparam logic [SAMPLE_W-1:0] CMD_RESTART  = 8'h52;

  // Flash reader FSM states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

endpackage

//--- hw/command_decoder.sv
`timescale 1ns/1ns

module command_decoder
  import ipod_pkg::*;
(
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic [SAMPLE_W-1:0] ascii_code,
  input  logic                ascii_valid,
  output logic                playing,
  output logic                backward,
  output logic                restart
);

  // Play and direction are levels, restart is a single pulse
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      playing  <= 1'b0;
      backward <= 1'b0;
      restart  <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (ascii_valid)
      begin
        case (ascii_code)
          CMD_PLAY:     playing  <= 1'b1;
          CMD_STOP:     playing  <= 1'b0;
          CMD_FORWARD:  backward <= 1'b0;
          CMD_BACKWARD: backward <= 1'b1;
          CMD_RESTART:  restart  <= 1'b1;
          // Anything else is not a command
          default:      ;
        endcase
      end
    end
  end

endmodule

//--- hw/speed_control.sv
`timescale 1ns/1ns

module speed_control
  import ipod_pkg::*;
(
  input  logic               CLK_50M,
  input  logic               arst_n,
  input  logic [2:0]         key_n,
  output logic [COUNT_W-1:0] divider_count
);

  // ========================================
  // Button synchronizers
  // ========================================
  logic [2:0] key_s1;
  logic [2:0] key_s2;
  logic [2:0] key_d;
  logic [2:0] press;

  // Buttons idle high, so reset to released
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_s1 <= 3'b111;
      key_s2 <= 3'b111;
      key_d  <= 3'b111;
    end
    else
    begin
      key_s1 <= key_n;
      key_s2 <= key_s1;
      key_d  <= key_s2;
    end
  end

  // High to low on the synchronized key
  assign press = key_d & ~key_s2;

  // ========================================
  // Divider count
  // ========================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      divider_count <= COUNT_DEFAULT;
    else if (press[2])
      divider_count <= COUNT_DEFAULT;
    else if (press[0])
    begin
      // Speed up, shorter period
      if (divider_count < COUNT_MIN + COUNT_STEP)
        divider_count <= COUNT_MIN;
      else
        divider_count <= divider_count - COUNT_STEP;
    end
    else if (press[1])
    begin
      // Slow down, longer period
      if (divider_count > COUNT_MAX - COUNT_STEP)
        divider_count <= COUNT_MAX;
      else
        divider_count <= divider_count + COUNT_STEP;
    end
  end

endmodule

//--- hw/sample_timer.sv
`timescale 1ns/1ns

module sample_timer
  import ipod_pkg::*;
(
  input  logic               CLK_50M,
  input  logic               arst_n,
  input  logic [COUNT_W-1:0] divider_count,
  output logic               sample_tick
);

  logic [COUNT_W-1:0] count_q;

  // Period is divider_count + 1 cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count_q     <= COUNT_DEFAULT;
      sample_tick <= 1'b0;
    end
    else if (count_q == '0)
    begin
      count_q     <= divider_count;
      sample_tick <= 1'b1;
    end
    else
    begin
      count_q     <= count_q - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- hw/flash_reader.sv
`timescale 1ns/1ns

module flash_reader
  import ipod_pkg::*;
(
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic                sample_tick,
  input  logic                playing,
  input  logic                backward,
  input  logic                restart,
  output logic                flash_read,
  output logic [ADDR_W-1:0]   flash_address,
  input  logic                flash_waitrequest,
  input  logic [DATA_W-1:0]   flash_readdata,
  input  logic                flash_readdatavalid,
  output logic [SAMPLE_W-1:0] sample,
  output logic                sample_valid
);

  logic [1:0]          state_q;
  logic [ADDR_W-1:0]   addr_q;
  // Half to play next, 0 is the lower 16 bits
  logic                half_q;
  logic [DATA_W-1:0]   word_q;
  logic                word_valid_q;
  logic                pending_q;
  logic                restart_hold_q;

  logic [DATA_W-1:0]   src_word;
  logic [SAMPLE_W-1:0] cur_byte;
  logic [ADDR_W-1:0]   next_addr;
  logic                next_same;
  logic                take_tick;
  logic                restart_now;
  logic                deliver;

  assign flash_address = addr_q;
  assign flash_read    = (state_q == ST_REQ);

  assign take_tick   = playing & (sample_tick | pending_q);
  assign restart_now = restart | restart_hold_q;

  // Returning data is used directly, otherwise the held word
  assign src_word = (state_q == ST_WAIT) ? flash_readdata : word_q;
  assign cur_byte = half_q ? src_word[DATA_W-1 -: SAMPLE_W]
                           : src_word[DATA_W/2-1 -: SAMPLE_W];

  assign deliver = (state_q == ST_IDLE && !restart_now && take_tick && word_valid_q)
                || (state_q == ST_WAIT && flash_readdatavalid);

  // ========================================
  // Position after the current half
  // ========================================
  always_comb
  begin
    next_addr = addr_q;
    next_same = 1'b1;
    if (!backward && half_q)
    begin
      next_same = 1'b0;
      next_addr = (addr_q == FLASH_LAST_ADDR) ? '0 : addr_q + 1'b1;
    end
    else if (backward && !half_q)
    begin
      next_same = 1'b0;
      next_addr = (addr_q == '0) ? FLASH_LAST_ADDR : addr_q - 1'b1;
    end
  end

  // ========================================
  // Read FSM and position
  // ========================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q        <= ST_IDLE;
      addr_q         <= '0;
      half_q         <= 1'b0;
      word_valid_q   <= 1'b0;
      pending_q      <= 1'b0;
      restart_hold_q <= 1'b0;
      sample_valid   <= 1'b0;
    end
    else
    begin
      sample_valid <= deliver;
      if (!playing)
        pending_q <= 1'b0;

      if (deliver)
      begin
        addr_q       <= next_addr;
        half_q       <= ~half_q;
        word_valid_q <= next_same;
      end

      case (state_q)
        ST_IDLE:
        begin
          if (restart_now)
          begin
            // Start of song in the current direction
            addr_q         <= backward ? FLASH_LAST_ADDR : '0;
            half_q         <= backward;
            word_valid_q   <= 1'b0;
            restart_hold_q <= 1'b0;
            pending_q      <= take_tick;
          end
          else if (take_tick)
          begin
            pending_q <= 1'b0;
            if (!word_valid_q)
              state_q <= ST_REQ;
          end
        end
        ST_REQ:
        begin
          if (!flash_waitrequest)
            state_q <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (flash_readdatavalid)
            state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase

      // Busy, so hold one tick and any restart for later
      if (state_q != ST_IDLE)
      begin
        if (sample_tick && playing)
          pending_q <= 1'b1;
        if (restart)
          restart_hold_q <= 1'b1;
      end
    end
  end

  // Data path
  always_ff @(posedge CLK_50M)
  begin
    if (state_q == ST_WAIT && flash_readdatavalid)
      word_q <= flash_readdata;
    if (deliver)
      sample <= cur_byte;
  end

endmodule

//--- hw/hex_display.sv
`timescale 1ns/1ns

module hex_display
  import ipod_pkg::*;
(
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic [COUNT_W-1:0]  divider_count,
  input  logic [SAMPLE_W-1:0] sample,
  input  logic                sample_valid,
  output logic [6:0]          hex0,
  output logic [6:0]          hex1,
  output logic [6:0]          hex2,
  output logic [6:0]          hex3,
  output logic [6:0]          hex4,
  output logic [6:0]          hex5
);

  logic [SAMPLE_W-1:0] sample_q;
  logic [SAMPLE_W-1:0] shown;

  // Segment a is bit 0, a lit segment is 0
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // New sample goes straight to the digits
  assign shown = sample_valid ? sample : sample_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sample_q <= '0;
      hex0     <= 7'h7F;
      hex1     <= 7'h7F;
      hex2     <= 7'h7F;
      hex3     <= 7'h7F;
      hex4     <= 7'h7F;
      hex5     <= 7'h7F;
    end
    else
    begin
      sample_q <= shown;
      hex0     <= seg7(divider_count[3:0]);
      hex1     <= seg7(divider_count[7:4]);
      hex2     <= seg7(divider_count[11:8]);
      hex3     <= seg7(divider_count[15:12]);
      hex4     <= seg7(shown[3:0]);
      hex5     <= seg7(shown[7:4]);
    end
  end

endmodule

//--- hw/ipod_top.sv
`timescale 1ns/1ns

module ipod_top (
  input  logic        CLK_50M,
  input  logic        arst_n,
  input  logic [7:0]  ascii_code,
  input  logic        ascii_valid,
  input  logic [2:0]  key_n,
  output logic        flash_read,
  output logic [22:0] flash_address,
  input  logic        flash_waitrequest,
  input  logic [31:0] flash_readdata,
  input  logic        flash_readdatavalid,
  output logic [7:0]  sample,
  output logic        sample_valid,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [6:0]  hex4,
  output logic [6:0]  hex5
);

  logic        playing;
  logic        backward;
  logic        restart;
  logic [15:0] divider_count;
  logic        sample_tick;

  // ========================================
  // Input side
  // ========================================
  command_decoder u_cmd (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .playing     (playing),
    .backward    (backward),
    .restart     (restart)
  );

  speed_control u_speed (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .key_n         (key_n),
    .divider_count (divider_count)
  );

  // ========================================
  // Playback
  // ========================================
  sample_timer u_timer (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .divider_count (divider_count),
    .sample_tick   (sample_tick)
  );

  flash_reader u_reader (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .sample_tick         (sample_tick),
    .playing             (playing),
    .backward            (backward),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid)
  );

  // Count on the low four digits, sample on the top two
  hex_display u_hex (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .divider_count (divider_count),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK_50M,
  output logic arst_n
);

  initial
  begin
    CLK_50M = 1'b0;
    forever #(PERIOD_NS / 2) CLK_50M = ~CLK_50M;
  end

  // Released a quarter period after a falling edge, away from both edges
  initial
  begin
    arst_n = 1'b0;
    #(PERIOD_NS * RESET_CYCLES + PERIOD_NS / 4) arst_n = 1'b1;
  end

endmodule

//--- tests/flash_model.sv
`timescale 1ns/1ns

module flash_model
  import ipod_pkg::*;
(
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  logic              flash_read,
  input  logic [ADDR_W-1:0] flash_address,
  output logic              flash_waitrequest,
  output logic [DATA_W-1:0] flash_readdata,
  output logic              flash_readdatavalid
);

  logic              wait_q     = 1'b0;
  logic              valid_q    = 1'b0;
  logic [DATA_W-1:0] data_q     = '0;
  logic              seeded     = 1'b0;
  logic              in_req     = 1'b0;
  logic              granted    = 1'b0;
  int unsigned       wait_left  = 0;
  int unsigned       delay_left = 0;
  logic [ADDR_W-1:0] addr_lat   = '0;

  assign flash_waitrequest   = wait_q;
  assign flash_readdata      = data_q;
  assign flash_readdatavalid = valid_q;

  // Lower half holds the address, upper half its inverse
  function automatic logic [DATA_W-1:0] word_at(input logic [ADDR_W-1:0] a);
    return {~a[15:0], a[15:0]};
  endfunction

  // Answers on the falling edge, the reader samples on the rising edge
  always @(negedge CLK_50M)
  begin
    if (!seeded)
    begin
      seeded = 1'b1;
      void'($urandom(32'h1c9e));
    end
    if (!arst_n)
    begin
      wait_q     = 1'b0;
      valid_q    = 1'b0;
      in_req     = 1'b0;
      granted    = 1'b0;
      delay_left = 0;
    end
    else
    begin
      valid_q = 1'b0;
      if (delay_left != 0)
      begin
        delay_left = delay_left - 1;
        if (delay_left == 0)
        begin
          valid_q = 1'b1;
          data_q  = word_at(addr_lat);
        end
      end

      if (granted)
      begin
        // Accepted at the rising edge just past
        granted    = 1'b0;
        in_req     = 1'b0;
        delay_left = 1 + ($urandom % 4);
      end
      else if (flash_read && !in_req)
      begin
        in_req    = 1'b1;
        addr_lat  = flash_address;
        wait_left = $urandom % 4;
        wait_q    = (wait_left != 0);
        granted   = (wait_left == 0);
      end
      else if (in_req)
      begin
        wait_left = wait_left - 1;
        if (wait_left == 0)
        begin
          wait_q  = 1'b0;
          granted = 1'b1;
        end
      end
    end
  end

endmodule

//--- tests/tb_ipod.sv
`timescale 1ns/1ns

module tb_ipod
  import ipod_pkg::*;
();

  localparam int CASE_DEPTH   = 64;
  localparam int PRESS_CYCLES = 5;

  logic                CLK_50M;
  logic                arst_n;
  logic [7:0]          ascii_code;
  logic                ascii_valid;
  logic [2:0]          key_n;
  logic                flash_read;
  logic [ADDR_W-1:0]   flash_address;
  logic                flash_waitrequest;
  logic [DATA_W-1:0]   flash_readdata;
  logic                flash_readdatavalid;
  logic [SAMPLE_W-1:0] sample;
  logic                sample_valid;
  logic [6:0]          hex0;
  logic [6:0]          hex1;
  logic [6:0]          hex2;
  logic [6:0]          hex3;
  logic [6:0]          hex4;
  logic [6:0]          hex5;

  logic [31:0]         cases [0:CASE_DEPTH-1];
  int                  errors       = 0;
  int                  checks       = 0;
  int unsigned         limit_cycles = 0;
  int unsigned         sample_count = 0;

  // Reference position, half is the next one to play
  logic [ADDR_W-1:0]   ref_addr     = '0;
  logic                ref_half     = 1'b0;
  logic                ref_backward = 1'b0;
  logic [SAMPLE_W-1:0] last_sample  = '0;
  logic [SAMPLE_W-1:0] exp_sample   = '0;
  logic                hold_check   = 1'b0;
  logic [ADDR_W-1:0]   held_addr    = '0;

  clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n)
  );

  ipod_top dut (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .ascii_code          (ascii_code),
    .ascii_valid         (ascii_valid),
    .key_n               (key_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3),
    .hex4                (hex4),
    .hex5                (hex5)
  );

  flash_model u_flash (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  // ========================================
  // Reference model
  // ========================================
  // Active low, segment a on bit 0
  function automatic logic [6:0] segments_for(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // Upper byte of the chosen half of the flash word
  function automatic logic [7:0] expected_sample(input logic [ADDR_W-1:0] a, input logic half);
    return half ? ~a[15:8] : a[15:8];
  endfunction

  task automatic advance_position();
    if (!ref_backward && ref_half)
      ref_addr = (ref_addr == FLASH_LAST_ADDR) ? '0 : ref_addr + 23'd1;
    else if (ref_backward && !ref_half)
      ref_addr = (ref_addr == '0) ? FLASH_LAST_ADDR : ref_addr - 23'd1;
    ref_half = ~ref_half;
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (actual == expected)
    else
    begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // ========================================
  // Monitors
  // ========================================
  always @(negedge CLK_50M)
  begin
    if (arst_n && sample_valid)
    begin
      exp_sample = expected_sample(ref_addr, ref_half);
      compare_value("sample", exp_sample, sample);
      last_sample = exp_sample;
      advance_position();
      sample_count++;
    end
  end

  // Avalon read rules, values as seen by the reader at each rising edge
  always @(posedge CLK_50M)
  begin
    if (arst_n)
    begin
      if (hold_check)
      begin
        compare_value("flash_address", held_addr, flash_address);
        compare_value("flash_read", 1, flash_read);
      end
      if (flash_read && !flash_waitrequest)
        compare_value("flash_address", ref_addr, flash_address);
      hold_check = flash_read && flash_waitrequest;
      held_addr  = flash_address;
    end
  end

  // ========================================
  // Stimulus tasks
  // ========================================
  task automatic send_byte(input logic [7:0] code);
    @(negedge CLK_50M);
    ascii_code  = code;
    ascii_valid = 1'b1;
    case (code)
      CMD_FORWARD:  ref_backward = 1'b0;
      CMD_BACKWARD: ref_backward = 1'b1;
      CMD_RESTART:
      begin
        ref_addr = ref_backward ? FLASH_LAST_ADDR : '0;
        ref_half = ref_backward;
      end
      default: ;
    endcase
    @(negedge CLK_50M);
    ascii_valid = 1'b0;
  endtask

  task automatic press_key(input int idx, input int times);
    repeat (times)
    begin
      @(negedge CLK_50M);
      key_n[idx] = 1'b0;
      repeat (PRESS_CYCLES) @(negedge CLK_50M);
      key_n[idx] = 1'b1;
      repeat (PRESS_CYCLES) @(negedge CLK_50M);
    end
  endtask

  task automatic await_samples(input int n);
    int unsigned target;
    target = sample_count + n;
    while (sample_count < target)
      @(posedge CLK_50M);
  endtask

  // Longest possible tick period, so any tick would be seen
  task automatic expect_quiet(input int periods);
    repeat (periods * (int'(COUNT_MAX) + 1))
    begin
      @(negedge CLK_50M);
      compare_value("sample_valid", 0, sample_valid);
      compare_value("flash_read", 0, flash_read);
    end
  endtask

  task automatic verify_display(input logic [15:0] count);
    @(negedge CLK_50M);
    compare_value("hex0", segments_for(count[3:0]), hex0);
    compare_value("hex1", segments_for(count[7:4]), hex1);
    compare_value("hex2", segments_for(count[11:8]), hex2);
    compare_value("hex3", segments_for(count[15:12]), hex3);
    compare_value("hex4", segments_for(last_sample[3:0]), hex4);
    compare_value("hex5", segments_for(last_sample[7:4]), hex5);
  endtask

  task automatic run_case(input logic [31:0] entry);
    case (entry[31:24])
      8'h43: send_byte(entry[7:0]);
      8'h53: await_samples(entry[15:0]);
      8'h4B: press_key(entry[17:16], entry[15:0]);
      8'h4E: expect_quiet(entry[15:0]);
      8'h56: verify_display(entry[15:0]);
      default:
      begin
        errors++;
        $display("case entry %h has an unknown operation code", entry);
      end
    endcase
  endtask

  // ========================================
  // Main sequence and watchdog
  // ========================================
  initial
  begin
    int total;
    int i;
    ascii_code  = 8'h00;
    ascii_valid = 1'b0;
    key_n       = 3'b111;
    for (i = 0; i < CASE_DEPTH; i++)
      cases[i] = '0;
    $readmemh("tests/ipod_cases.txt", cases);
    if (cases[0] == '0)
    begin
      errors++;
      $display("the case file could not be read or holds no cases");
    end

    // Sample and quiet periods set the time budget
    total = 0;
    for (i = 0; i < CASE_DEPTH; i++)
      if (cases[i][31:24] == 8'h53 || cases[i][31:24] == 8'h4E)
        total += int'(cases[i][15:0]);
    limit_cycles = total * (int'(COUNT_MAX) + 20) + 10000;

    wait (arst_n === 1'b1);
    repeat (3) @(negedge CLK_50M);
    compare_value("flash_read", 0, flash_read);
    compare_value("sample_valid", 0, sample_valid);

    i = 0;
    while (i < CASE_DEPTH && cases[i][31:24] != 8'h00)
    begin
      run_case(cases[i]);
      i++;
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge CLK_50M);
    $display("run timed out after %0d cycles, errors so far %0d", limit_cycles, errors);
    $display("test failed");
    $finish;
  end

endmodule

//--- tests/ipod_cases.txt
// One word per line: op[31:24] key[23:16] value[15:0]
// op 43 command byte, 53 samples, 4B key presses, 4E quiet periods, 56 shown count
56000470 // count after reset
43000045 // E play
53000006 // forward from address 0
43000044 // D stop
4E000003 // nothing while stopped
43000045 // E resume
53000003
43000042 // B backward
43000052 // R restart at the last address
53000005
43000046 // F forward again
53000004
43000044 // D stop
4B000001 // speed up once
56000450
4B010002 // slow down twice
56000490
4B00001E // speed up past the limit
56000100
43000045 // E play at the fastest rate
53000004
43000044 // D stop
4B020001 // reset the rate
56000470

//--- list.f
hw/ipod_pkg.sv
hw/command_decoder.sv
hw/speed_control.sv
hw/sample_timer.sv
hw/flash_reader.sv
hw/hex_display.sv
hw/ipod_top.sv
tests/clock_gen.sv
tests/flash_model.sv
tests/tb_ipod.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ipod -f list.f
./obj_dir/Vtb_ipod > sim.log
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
else
  echo "simulation did not report a pass, see sim.log"
  exit 1
fi
